// File: design/fetch_pkg.sv
package fetch_pkg;

    // trap bus, one bit per exception cause
    localparam int unsigned TRAP_LEN = 16;

    // bit indices follow the riscv mcause codes
    localparam int unsigned TRAP_INST_ADDR_MISALIGNED = 0;
    localparam int unsigned TRAP_INST_ACCESS_FAULT    = 1;
    localparam int unsigned TRAP_INST_PAGE_FAULT      = 12;

    // privilege levels, encoded as in mstatus.mpp
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_e;

    // fetch unit states
    // misaligned pc jumps from IDLE straight to RESP
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        XLATE = 2'd1,
        READ  = 2'd2,
        RESP  = 2'd3
    } fetch_state_e;

endpackage

// File: design/sv32_pkg.sv
package sv32_pkg;

    // pte flag bits
    localparam int unsigned PTE_V = 0;
    localparam int unsigned PTE_R = 1;
    localparam int unsigned PTE_W = 2;
    localparam int unsigned PTE_X = 3;
    localparam int unsigned PTE_U = 4;

    // ppn fields of a pte
    localparam int unsigned PTE_PPN0_LSB = 10;
    localparam int unsigned PTE_PPN0_W   = 10;
    localparam int unsigned PTE_PPN1_LSB = 20;
    localparam int unsigned PTE_PPN1_W   = 12;

    // 4 KiB page and 4 MiB superpage offsets
    localparam int unsigned PAGE_OFFSET_W      = 12;
    localparam int unsigned SUPERPAGE_OFFSET_W = 22;
    localparam int unsigned VPN_W              = 10;

    // walker states
    typedef enum logic [1:0] {
        W_IDLE = 2'd0,
        W_L1   = 2'd1,
        W_L0   = 2'd2,
        W_DONE = 2'd3
    } walk_state_e;

    // axi rresp codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

endpackage

// File: design/mem_rd_if.sv
`timescale 1ns/1ps

interface mem_rd_if #(
    parameter int ADDR_W = 32
) ();

    // request, transfers on valid and ready
    logic              req_valid;
    logic              req_ready;
    logic [ADDR_W-1:0] req_addr;

    // single-cycle response pulse
    logic              resp_valid;
    logic [31:0]       resp_data;
    // set for slverr or decerr
    logic              resp_err;

    modport requester (
        output req_valid, req_addr,
        input  req_ready, resp_valid, resp_data, resp_err
    );

    modport server (
        input  req_valid, req_addr,
        output req_ready, resp_valid, resp_data, resp_err
    );

endinterface

// File: design/sv32_walker.sv
`timescale 1ns/1ps

module sv32_walker import fetch_pkg::*, sv32_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              satp_mode_i,
    input  logic [21:0]       satp_ppn_i,
    input  priv_e             priv_i,
    input  logic              xlate_req_i,
    input  logic [31:0]       vaddr_i,
    output logic              xlate_done_o,
    output logic [ADDR_W-1:0] paddr_o,
    output logic              xlate_pf_o,
    output logic              xlate_af_o,
    input  logic              flush_i,
    mem_rd_if.requester       rd
);

    walk_state_e       state_q, state_d;
    logic              req_q, pend_q, pf_q, af_q;
    logic [ADDR_W-1:0] addr_q, paddr_q;
    logic [31:0]       pte;
    logic              bypass, rd_fire, resp_take;
    logic              pte_bad, pte_leaf, perm_fault, super_misaligned;
    logic              issue, finish, pf_d, af_d;
    logic [33:0]       addr_d, pa_d;

    assign pte = rd.resp_data;
    // machine mode or bare satp skip the walk
    assign bypass = !satp_mode_i || (priv_i == PRIV_M);

    // no new request until the previous response came back
    assign rd.req_valid = req_q && !pend_q;
    assign rd.req_addr  = addr_q;
    assign rd_fire      = rd.req_valid && rd.req_ready;
    // a response seen while our own request still waits is stale
    assign resp_take    = rd.resp_valid && pend_q && !req_q;

    // invalid, or reserved w without r
    assign pte_bad          = !pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R]);
    assign pte_leaf         = pte[PTE_R] || pte[PTE_X];
    // u page only from user mode, s page never from user mode
    assign perm_fault       = !pte[PTE_X] || (pte[PTE_U] != (priv_i == PRIV_U));
    assign super_misaligned = |pte[PTE_PPN0_LSB +: PTE_PPN0_W];

    always_comb begin
        state_d = state_q;
        issue   = 1'b0;
        finish  = 1'b0;
        pf_d    = 1'b0;
        af_d    = 1'b0;
        // level 1 pte at satp.ppn * 4096 + vpn1 * 4
        addr_d  = {satp_ppn_i, vaddr_i[SUPERPAGE_OFFSET_W +: VPN_W], 2'b00};
        pa_d    = {2'b00, vaddr_i};
        case (state_q)
            W_IDLE: begin
                if (xlate_req_i) begin
                    if (bypass) begin
                        finish = 1'b1;
                    end else begin
                        issue   = 1'b1;
                        state_d = W_L1;
                    end
                end
            end
            W_L1: begin
                if (resp_take) begin
                    if (rd.resp_err) begin
                        finish = 1'b1;
                        af_d   = 1'b1;
                    end else if (pte_bad) begin
                        finish = 1'b1;
                        pf_d   = 1'b1;
                    end else if (pte_leaf) begin
                        // superpage leaf
                        finish = 1'b1;
                        pf_d   = perm_fault || super_misaligned;
                        pa_d   = {pte[PTE_PPN1_LSB +: PTE_PPN1_W],
                                  vaddr_i[SUPERPAGE_OFFSET_W-1:0]};
                    end else begin
                        // pointer, go one level down
                        issue   = 1'b1;
                        addr_d  = {pte[PTE_PPN0_LSB +: PTE_PPN0_W + PTE_PPN1_W],
                                   vaddr_i[PAGE_OFFSET_W +: VPN_W], 2'b00};
                        state_d = W_L0;
                    end
                end
            end
            W_L0: begin
                if (resp_take) begin
                    finish = 1'b1;
                    if (rd.resp_err) begin
                        af_d = 1'b1;
                    end else if (pte_bad || !pte_leaf) begin
                        pf_d = 1'b1;
                    end else begin
                        pf_d = perm_fault;
                        pa_d = {pte[PTE_PPN0_LSB +: PTE_PPN0_W + PTE_PPN1_W],
                                vaddr_i[PAGE_OFFSET_W-1:0]};
                    end
                end
            end
            default: begin
                state_d = W_IDLE;
            end
        endcase
        if (finish) begin
            state_d = W_DONE;
        end
        if (flush_i) begin
            state_d = W_IDLE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= W_IDLE;
            req_q   <= 1'b0;
            pend_q  <= 1'b0;
            pf_q    <= 1'b0;
            af_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (flush_i) begin
                req_q <= 1'b0;
            end else if (issue) begin
                req_q <= 1'b1;
            end else if (rd_fire) begin
                req_q <= 1'b0;
            end
            // outstanding read survives a flush
            if (rd_fire) begin
                pend_q <= 1'b1;
            end else if (rd.resp_valid) begin
                pend_q <= 1'b0;
            end
            if (finish) begin
                pf_q <= pf_d;
                af_q <= af_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            addr_q <= addr_d[ADDR_W-1:0];
        end
        if (finish) begin
            paddr_q <= pa_d[ADDR_W-1:0];
        end
    end

    assign xlate_done_o = (state_q == W_DONE);
    assign paddr_o      = paddr_q;
    assign xlate_pf_o   = pf_q;
    assign xlate_af_o   = af_q;

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import sv32_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    mem_rd_if.server          walk_rd,
    mem_rd_if.server          fetch_rd,
    output logic [ADDR_W-1:0] m_araddr_o,
    output logic              m_arvalid_o,
    input  logic              m_arready_i,
    input  logic [31:0]       m_rdata_i,
    input  logic [1:0]        m_rresp_i,
    input  logic              m_rvalid_i,
    output logic              m_rready_o
);

    logic              arvalid_q, rready_q, resp_q, owner_q;
    logic [ADDR_W-1:0] araddr_q;
    logic [31:0]       rdata_q;
    logic              rerr_q;
    logic              busy, walk_win, fetch_win, r_beat;
    resp_e             rresp;

    // one read at a time, from grant until the response pulse
    assign busy = arvalid_q || rready_q || resp_q;

    // walker wins ties
    assign walk_rd.req_ready  = !busy;
    assign fetch_rd.req_ready = !busy && !walk_rd.req_valid;
    assign walk_win  = walk_rd.req_valid && walk_rd.req_ready;
    assign fetch_win = fetch_rd.req_valid && fetch_rd.req_ready;

    assign rresp  = resp_e'(m_rresp_i);
    assign r_beat = m_rvalid_i && rready_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
            resp_q    <= 1'b0;
            owner_q   <= 1'b0;
        end else begin
            // ar goes out the cycle after the grant
            if (walk_win || fetch_win) begin
                arvalid_q <= 1'b1;
                rready_q  <= 1'b1;
                owner_q   <= fetch_win;
            end else if (arvalid_q && m_arready_i) begin
                arvalid_q <= 1'b0;
            end
            if (r_beat) begin
                rready_q <= 1'b0;
            end
            // response pulse also frees the channel
            resp_q <= r_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (walk_win) begin
            araddr_q <= walk_rd.req_addr;
        end else if (fetch_win) begin
            araddr_q <= fetch_rd.req_addr;
        end
        if (r_beat) begin
            rdata_q <= m_rdata_i;
            rerr_q  <= (rresp == SLVERR) || (rresp == DECERR);
        end
    end

    assign m_araddr_o  = araddr_q;
    assign m_arvalid_o = arvalid_q;
    assign m_rready_o  = rready_q;

    // route the beat back to whoever owns the grant
    assign walk_rd.resp_valid  = resp_q && !owner_q;
    assign fetch_rd.resp_valid = resp_q && owner_q;
    assign walk_rd.resp_data   = rdata_q;
    assign fetch_rd.resp_data  = rdata_q;
    assign walk_rd.resp_err    = rerr_q;
    assign fetch_rd.resp_err   = rerr_q;

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         fetch_pc_i,
    input  logic                fetch_valid_i,
    output logic                fetch_ready_o,
    input  logic                fetch_flush_i,
    input  logic                fetch_ready_i,
    output logic                fetch_valid_o,
    output logic [31:0]         fetch_addr_o,
    output logic [31:0]         fetch_inst_o,
    output logic [TRAP_LEN-1:0] fetch_trap_o,
    output logic                xlate_req_o,
    output logic [31:0]         vaddr_o,
    input  logic                xlate_done_i,
    input  logic [ADDR_W-1:0]   paddr_i,
    input  logic                xlate_pf_i,
    input  logic                xlate_af_i,
    mem_rd_if.requester         rd
);

    fetch_state_e        state_q, state_d;
    logic                ready_q, rd_req_q, discard_q;
    logic [31:0]         pc_q, inst_q;
    logic [ADDR_W-1:0]   paddr_q;
    logic [TRAP_LEN-1:0] trap_q;
    logic                accept, misaligned, xlate_ok, rd_fire, own_resp;

    // flush beats a new request in the same cycle
    assign fetch_ready_o = ready_q && !fetch_flush_i;
    assign accept        = fetch_valid_i && fetch_ready_o;
    assign misaligned    = |fetch_pc_i[1:0];
    assign xlate_ok      = xlate_done_i && !xlate_pf_i && !xlate_af_i;

    // hold the request back while a flushed read is still out
    assign rd.req_valid = rd_req_q && !discard_q;
    assign rd.req_addr  = paddr_q;
    assign rd_fire      = rd.req_valid && rd.req_ready;
    assign own_resp     = rd.resp_valid && !discard_q && (state_q == READ) && !rd_req_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = misaligned ? RESP : XLATE;
                end
            end
            XLATE: begin
                if (xlate_done_i) begin
                    state_d = xlate_ok ? READ : RESP;
                end
            end
            READ: begin
                if (own_resp) begin
                    state_d = RESP;
                end
            end
            default: begin
                // hold the response until taken
                if (fetch_ready_i) begin
                    state_d = IDLE;
                end
            end
        endcase
        if (fetch_flush_i) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= IDLE;
            ready_q   <= 1'b0;
            rd_req_q  <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            state_q <= state_d;
            ready_q <= (state_d == IDLE);
            if (fetch_flush_i) begin
                rd_req_q <= 1'b0;
            end else if ((state_q == XLATE) && xlate_ok) begin
                rd_req_q <= 1'b1;
            end else if (rd_fire) begin
                rd_req_q <= 1'b0;
            end
            // read in flight at flush time, swallow its response
            if (fetch_flush_i && (state_q == READ) && (!rd_req_q || rd_fire)
                    && !rd.resp_valid) begin
                discard_q <= 1'b1;
            end else if (rd.resp_valid) begin
                discard_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q   <= fetch_pc_i;
            inst_q <= '0;
            trap_q <= '0;
            trap_q[TRAP_INST_ADDR_MISALIGNED] <= misaligned;
        end
        if ((state_q == XLATE) && xlate_done_i) begin
            paddr_q <= paddr_i;
            trap_q[TRAP_INST_PAGE_FAULT]   <= xlate_pf_i;
            trap_q[TRAP_INST_ACCESS_FAULT] <= xlate_af_i;
        end
        // bus error gives an access fault and a zero word
        if (own_resp) begin
            trap_q[TRAP_INST_ACCESS_FAULT] <= rd.resp_err;
            inst_q <= rd.resp_err ? '0 : rd.resp_data;
        end
    end

    assign fetch_valid_o = (state_q == RESP);
    assign fetch_addr_o  = pc_q;
    assign fetch_inst_o  = inst_q;
    assign fetch_trap_o  = trap_q;
    assign xlate_req_o   = (state_q == XLATE);
    assign vaddr_o       = pc_q;

endmodule

// File: design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         fetch_pc_i,
    input  logic                fetch_valid_i,
    output logic                fetch_ready_o,
    input  logic                satp_mode_i,
    input  logic [21:0]         satp_ppn_i,
    input  priv_e               priv_i,
    input  logic                fetch_flush_i,
    output logic                fetch_valid_o,
    output logic [31:0]         fetch_addr_o,
    output logic [31:0]         fetch_inst_o,
    output logic [TRAP_LEN-1:0] fetch_trap_o,
    input  logic                fetch_ready_i,
    output logic [ADDR_W-1:0]   m_araddr_o,
    output logic                m_arvalid_o,
    input  logic                m_arready_i,
    input  logic [31:0]         m_rdata_i,
    input  logic [1:0]          m_rresp_i,
    input  logic                m_rvalid_i,
    output logic                m_rready_o
);

    // fetch unit to walker
    logic              xlate_req, xlate_done, xlate_pf, xlate_af;
    logic [31:0]       vaddr;
    logic [ADDR_W-1:0] paddr;

    // both share the one axi read port
    mem_rd_if #(.ADDR_W(ADDR_W)) walk_rd ();
    mem_rd_if #(.ADDR_W(ADDR_W)) fetch_rd ();

    fetch_unit #(.ADDR_W(ADDR_W)) fetch_unit_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_flush_i (fetch_flush_i),
        .fetch_ready_i (fetch_ready_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_addr_o  (fetch_addr_o),
        .fetch_inst_o  (fetch_inst_o),
        .fetch_trap_o  (fetch_trap_o),
        .xlate_req_o   (xlate_req),
        .vaddr_o       (vaddr),
        .xlate_done_i  (xlate_done),
        .paddr_i       (paddr),
        .xlate_pf_i    (xlate_pf),
        .xlate_af_i    (xlate_af),
        .rd            (fetch_rd.requester)
    );

    sv32_walker #(.ADDR_W(ADDR_W)) walker_i (
        .clk          (clk),
        .rst          (rst),
        .satp_mode_i  (satp_mode_i),
        .satp_ppn_i   (satp_ppn_i),
        .priv_i       (priv_i),
        .xlate_req_i  (xlate_req),
        .vaddr_i      (vaddr),
        .xlate_done_o (xlate_done),
        .paddr_o      (paddr),
        .xlate_pf_o   (xlate_pf),
        .xlate_af_o   (xlate_af),
        .flush_i      (fetch_flush_i),
        .rd           (walk_rd.requester)
    );

    mem_arbiter #(.ADDR_W(ADDR_W)) arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .walk_rd     (walk_rd.server),
        .fetch_rd    (fetch_rd.server),
        .m_araddr_o  (m_araddr_o),
        .m_arvalid_o (m_arvalid_o),
        .m_arready_i (m_arready_i),
        .m_rdata_i   (m_rdata_i),
        .m_rresp_i   (m_rresp_i),
        .m_rvalid_i  (m_rvalid_i),
        .m_rready_o  (m_rready_o)
    );

endmodule

// File: test/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker import fetch_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         pc_i,
    input  logic                req_valid_i,
    input  logic                req_ready_i,
    input  logic                valid_i,
    input  logic                taken_i,
    input  logic [31:0]         addr_i,
    input  logic [31:0]         inst_i,
    input  logic [TRAP_LEN-1:0] trap_i,
    input  logic                arvalid_i,
    input  logic                rready_i,
    input  logic                exp_push_i,
    input  int                  exp_id_i,
    input  logic [31:0]         exp_addr_i,
    input  logic [31:0]         exp_inst_i,
    input  logic [TRAP_LEN-1:0] exp_trap_i,
    output int                  pending_o,
    output int                  errors_o
);

    localparam int DEPTH = 32;

    // expected responses in issue order
    int                  id_q   [DEPTH];
    logic [31:0]         addr_q [DEPTH];
    logic [31:0]         inst_q [DEPTH];
    logic [TRAP_LEN-1:0] trap_q [DEPTH];
    int                  wr_ptr = 0;
    int                  rd_ptr = 0;
    int                  errors = 0;

    // last cycle's response when it was not taken
    logic                held_q = 1'b0;
    logic [31:0]         held_addr, held_inst;
    logic [TRAP_LEN-1:0] held_trap;
    // misaligned fetch between acceptance and response
    logic                misaligned_q = 1'b0;

    task automatic compare_field(input int id, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED entry %0d %s: expected %h, actual %h",
                     id, field, expected, actual);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            // handshake outputs stay low in reset
            if (valid_i || req_ready_i || arvalid_i || rready_i) begin
                $display("a DUT handshake output was high during reset");
                errors++;
            end
        end else begin
            if (exp_push_i) begin
                id_q[wr_ptr % DEPTH]   = exp_id_i;
                addr_q[wr_ptr % DEPTH] = exp_addr_i;
                inst_q[wr_ptr % DEPTH] = exp_inst_i;
                trap_q[wr_ptr % DEPTH] = exp_trap_i;
                wr_ptr++;
            end
            if (req_valid_i && req_ready_i && (pc_i[1:0] != 2'b00)) begin
                misaligned_q = 1'b1;
            end
            // misaligned pc never touches memory
            if (misaligned_q && arvalid_i) begin
                $display("AR channel was asserted during a misaligned fetch");
                errors++;
            end
            if (held_q && (!valid_i || addr_i !== held_addr || inst_i !== held_inst
                    || trap_i !== held_trap)) begin
                $display("response changed while fetch_ready_i held it back");
                errors++;
            end
            if (valid_i && taken_i) begin
                if (rd_ptr == wr_ptr) begin
                    $display("DUT returned a response that no fetch expected");
                    errors++;
                end else begin
                    compare_field(id_q[rd_ptr % DEPTH], "addr", addr_q[rd_ptr % DEPTH], addr_i);
                    compare_field(id_q[rd_ptr % DEPTH], "inst", inst_q[rd_ptr % DEPTH], inst_i);
                    compare_field(id_q[rd_ptr % DEPTH], "trap",
                                  32'(trap_q[rd_ptr % DEPTH]), 32'(trap_i));
                    rd_ptr++;
                end
                misaligned_q = 1'b0;
            end
            held_q    = valid_i && !taken_i;
            held_addr = addr_i;
            held_inst = inst_i;
            held_trap = trap_i;
        end
    end

    assign pending_o = wr_ptr - rd_ptr;
    assign errors_o  = errors;

endmodule

// File: test/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

    localparam int          NUM_ENTRIES = 16;
    localparam int          TIMEOUT     = 200;
    localparam logic [31:0] SEED        = 32'h66f0_9cb1;
    localparam logic [31:0] INST_KEY    = 32'hA5A5_0000;
    localparam logic [21:0] ROOT_PPN    = 22'h00100;
    localparam logic [1:0]  RESP_OKAY   = 2'b00;
    localparam logic [1:0]  RESP_DECERR = 2'b11;

    // pte flag bytes, v r w x u from bit 0 up
    localparam logic [7:0] PTE_PTR = 8'h01;
    localparam logic [7:0] PTE_SX  = 8'h0b;
    localparam logic [7:0] PTE_UX  = 8'h1b;
    localparam logic [7:0] PTE_URO = 8'h13;

    // trap bus values, riscv cause numbers as bit positions
    localparam logic [TRAP_LEN-1:0] TRAP_NONE = 16'h0000;
    localparam logic [TRAP_LEN-1:0] TRAP_MA   = 16'h0001;
    localparam logic [TRAP_LEN-1:0] TRAP_AF   = 16'h0002;
    localparam logic [TRAP_LEN-1:0] TRAP_PF   = 16'h1000;

    logic                clk;
    logic                rst;
    logic [31:0]         fetch_pc_i;
    logic                fetch_valid_i, fetch_ready_o, satp_mode_i, fetch_flush_i;
    logic [21:0]         satp_ppn_i;
    priv_e               priv_i;
    logic                fetch_valid_o, fetch_ready_i;
    logic [31:0]         fetch_addr_o, fetch_inst_o;
    logic [TRAP_LEN-1:0] fetch_trap_o;
    logic [31:0]         m_araddr_o, m_rdata_i;
    logic                m_arvalid_o, m_arready_i, m_rvalid_i, m_rready_o;
    logic [1:0]          m_rresp_i;

    // expected response handed to the checker at acceptance
    logic                exp_push;
    int                  exp_id;
    logic [31:0]         exp_addr, exp_inst;
    logic [TRAP_LEN-1:0] exp_trap;
    int                  pending, check_errors;
    int                  timeouts;

    // stimulus table
    logic [31:0]         tab_pc    [NUM_ENTRIES];
    logic                tab_mode  [NUM_ENTRIES];
    priv_e               tab_priv  [NUM_ENTRIES];
    logic                tab_flush [NUM_ENTRIES];
    logic [31:0]         tab_inst  [NUM_ENTRIES];
    logic [TRAP_LEN-1:0] tab_trap  [NUM_ENTRIES];
    int                  n_entries;

    // sparse memory, page table words only
    logic [31:0]         pte_mem [logic [31:0]];

    fetch_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_ready_o (fetch_ready_o),
        .satp_mode_i   (satp_mode_i),
        .satp_ppn_i    (satp_ppn_i),
        .priv_i        (priv_i),
        .fetch_flush_i (fetch_flush_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_addr_o  (fetch_addr_o),
        .fetch_inst_o  (fetch_inst_o),
        .fetch_trap_o  (fetch_trap_o),
        .fetch_ready_i (fetch_ready_i),
        .m_araddr_o    (m_araddr_o),
        .m_arvalid_o   (m_arvalid_o),
        .m_arready_i   (m_arready_i),
        .m_rdata_i     (m_rdata_i),
        .m_rresp_i     (m_rresp_i),
        .m_rvalid_i    (m_rvalid_i),
        .m_rready_o    (m_rready_o)
    );

    fetch_checker checker_i (
        .clk         (clk),
        .rst         (rst),
        .pc_i        (fetch_pc_i),
        .req_valid_i (fetch_valid_i),
        .req_ready_i (fetch_ready_o),
        .valid_i     (fetch_valid_o),
        .taken_i     (fetch_ready_i),
        .addr_i      (fetch_addr_o),
        .inst_i      (fetch_inst_o),
        .trap_i      (fetch_trap_o),
        .arvalid_i   (m_arvalid_o),
        .rready_i    (m_rready_o),
        .exp_push_i  (exp_push),
        .exp_id_i    (exp_id),
        .exp_addr_i  (exp_addr),
        .exp_inst_i  (exp_inst),
        .exp_trap_i  (exp_trap),
        .pending_o   (pending),
        .errors_o    (check_errors)
    );

    always #20 clk = ~clk;

    // inputs change 2 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    task automatic add_entry(input logic [31:0] pc, input logic mode, input priv_e priv,
                             input logic flush, input logic [31:0] pa,
                             input logic [TRAP_LEN-1:0] trap);
        tab_pc[n_entries]    = pc;
        tab_mode[n_entries]  = mode;
        tab_priv[n_entries]  = priv;
        tab_flush[n_entries] = flush;
        // trapped fetches return a zero word
        tab_inst[n_entries]  = (trap != '0) ? 32'h0 : (pa ^ INST_KEY);
        tab_trap[n_entries]  = trap;
        n_entries++;
    endtask

    task automatic load_page_tables();
        // root table at ppn 0x100, level 0 table at ppn 0x101
        pte_mem[32'h0010_0004] = make_pte(22'h00101, PTE_PTR);
        pte_mem[32'h0010_0008] = make_pte(22'h00c00, PTE_SX);
        // superpage with ppn0 set
        pte_mem[32'h0010_000c] = make_pte(22'h01001, PTE_SX);
        pte_mem[32'h0010_1000] = make_pte(22'h00200, PTE_UX);
        pte_mem[32'h0010_1004] = make_pte(22'h00201, PTE_SX);
        pte_mem[32'h0010_1008] = 32'h0;
        pte_mem[32'h0010_100c] = make_pte(22'h00202, PTE_URO);
    endtask

    task automatic load_table();
        // bare mode and machine mode
        add_entry(32'h0000_1000, 1'b0, PRIV_S, 1'b0, 32'h0000_1000, TRAP_NONE);
        add_entry(32'h0000_2004, 1'b1, PRIV_M, 1'b0, 32'h0000_2004, TRAP_NONE);
        // 4 KiB pages and a 4 MiB superpage
        add_entry(32'h0040_0010, 1'b1, PRIV_U, 1'b0, 32'h0020_0010, TRAP_NONE);
        add_entry(32'h0040_1020, 1'b1, PRIV_S, 1'b0, 32'h0020_1020, TRAP_NONE);
        add_entry(32'h0081_2344, 1'b1, PRIV_S, 1'b0, 32'h00c1_2344, TRAP_NONE);
        // invalid, no x, u from s, s from u, misaligned superpage
        add_entry(32'h0040_2000, 1'b1, PRIV_U, 1'b0, 32'h0, TRAP_PF);
        add_entry(32'h0040_3000, 1'b1, PRIV_U, 1'b0, 32'h0, TRAP_PF);
        add_entry(32'h0040_0000, 1'b1, PRIV_S, 1'b0, 32'h0, TRAP_PF);
        add_entry(32'h0040_1000, 1'b1, PRIV_U, 1'b0, 32'h0, TRAP_PF);
        add_entry(32'h00c0_0100, 1'b1, PRIV_S, 1'b0, 32'h0, TRAP_PF);
        // decerr on the instruction read, then a misaligned pc
        add_entry(32'h8000_0010, 1'b0, PRIV_M, 1'b0, 32'h0, TRAP_AF);
        add_entry(32'h0000_1002, 1'b0, PRIV_S, 1'b0, 32'h0, TRAP_MA);
        // flushed mid-walk, no response
        add_entry(32'h0040_0010, 1'b1, PRIV_U, 1'b1, 32'h0, TRAP_NONE);
        add_entry(32'h0081_0000, 1'b1, PRIV_S, 1'b0, 32'h00c1_0000, TRAP_NONE);
        add_entry(32'h0040_0006, 1'b1, PRIV_U, 1'b0, 32'h0, TRAP_MA);
        add_entry(32'h0040_0ffc, 1'b1, PRIV_U, 1'b0, 32'h0020_0ffc, TRAP_NONE);
    endtask

    // pulse flush once the walk has put its first read on AR
    task automatic flush_walk(input int idx);
        int cnt;
        cnt = 0;
        while (!m_arvalid_o && cnt < TIMEOUT) begin
            step_cycle();
            cnt++;
        end
        if (!m_arvalid_o) begin
            $display("timeout waiting for the walk read of entry %0d", idx);
            timeouts++;
        end
        fetch_flush_i = 1'b1;
        step_cycle();
        fetch_flush_i = 1'b0;
    endtask

    task automatic run_entry(input int idx);
        int cnt;
        cnt = 0;
        // satp and priv only change while the DUT is idle
        while (!fetch_ready_o && cnt < TIMEOUT) begin
            step_cycle();
            cnt++;
        end
        if (!fetch_ready_o) begin
            $display("timeout waiting for fetch_ready_o before entry %0d", idx);
            timeouts++;
        end else begin
            fetch_pc_i    = tab_pc[idx];
            satp_mode_i   = tab_mode[idx];
            priv_i        = tab_priv[idx];
            fetch_valid_i = 1'b1;
            exp_push      = !tab_flush[idx];
            exp_id        = idx;
            exp_addr      = tab_pc[idx];
            exp_inst      = tab_inst[idx];
            exp_trap      = tab_trap[idx];
            step_cycle();
            fetch_valid_i = 1'b0;
            exp_push      = 1'b0;
            if (tab_flush[idx]) begin
                flush_walk(idx);
            end
        end
    endtask

    // AXI4-Lite read slave, 0 to 3 cycles on arready and rvalid
    task automatic drive_read_beat(input logic [31:0] addr);
        m_rvalid_i = 1'b1;
        if (addr >= 32'h8000_0000) begin
            m_rresp_i = RESP_DECERR;
            m_rdata_i = 32'h0;
        end else if (pte_mem.exists(addr)) begin
            m_rresp_i = RESP_OKAY;
            m_rdata_i = pte_mem[addr];
        end else begin
            m_rresp_i = RESP_OKAY;
            m_rdata_i = addr ^ INST_KEY;
        end
    endtask

    initial begin : axi_slave
        int          delay;
        logic [31:0] addr;
        m_arready_i = 1'b0;
        m_rvalid_i  = 1'b0;
        m_rdata_i   = 32'h0;
        m_rresp_i   = RESP_OKAY;
        forever begin
            step_cycle();
            if (m_arvalid_o) begin
                delay = $urandom_range(3, 0);
                repeat (delay) step_cycle();
                addr        = m_araddr_o;
                m_arready_i = 1'b1;
                step_cycle();
                m_arready_i = 1'b0;
                delay = $urandom_range(3, 0);
                repeat (delay) step_cycle();
                // rready is up for the whole outstanding read
                drive_read_beat(addr);
                step_cycle();
                m_rvalid_i = 1'b0;
            end
        end
    end

    // random back-pressure on the response port
    initial begin
        fetch_ready_i = 1'b0;
        forever begin
            step_cycle();
            fetch_ready_i = ($urandom_range(3, 0) != 0);
        end
    end

    initial begin : main
        int idx;
        int cnt;
        void'($urandom(SEED));
        clk           = 1'b0;
        rst           = 1'b1;
        fetch_pc_i    = 32'h0;
        fetch_valid_i = 1'b0;
        satp_mode_i   = 1'b0;
        satp_ppn_i    = ROOT_PPN;
        priv_i        = PRIV_M;
        fetch_flush_i = 1'b0;
        exp_push      = 1'b0;
        exp_id        = 0;
        exp_addr      = 32'h0;
        exp_inst      = 32'h0;
        exp_trap      = '0;
        timeouts      = 0;
        n_entries     = 0;
        load_page_tables();
        load_table();
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        for (idx = 0; idx < n_entries && timeouts == 0; idx++) begin
            run_entry(idx);
        end
        // wait for the last responses
        cnt = 0;
        while (pending != 0 && cnt < TIMEOUT) begin
            step_cycle();
            cnt++;
        end
        if (pending != 0) begin
            $display("timeout with %0d responses still missing", pending);
            timeouts++;
        end
        $display("result: %0d check errors, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: build.f
design/fetch_pkg.sv
design/sv32_pkg.sv
design/mem_rd_if.sv
design/sv32_walker.sv
design/mem_arbiter.sv
design/fetch_unit.sv
design/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module fetch_tb -f build.f -o fetch_sim
./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation passed"
